// File: apu_consts.svh
`ifndef APU_CONSTS_SVH
`define APU_CONSTS_SVH

// Frame LFSR
`define LFSR_W 15

// Aclk counts after an LFSR clear at which each step fires

`define STEP_0 3728
`define STEP_1 7456
`define STEP_2 11185
`define STEP_3 14914   // Last step of four-step mode
`define STEP_4 18640   // Last step of five-step mode

// LFSR states reached after the step counts above, starting from all ones
// Shift is to the left, new bit enters at bit 0

`define PLA_0 15'h1061
`define PLA_1 15'h3603
`define PLA_2 15'h2cd3
`define PLA_3 15'h0a1f
`define PLA_4 15'h7185

// All-zero state, the feedback cannot leave it on its own
`define PLA_LOCK 15'h0000

`endif

// File: apu_pkg.sv
`include "apu_consts.svh"

package apu_pkg;

	// Frame LFSR state
	typedef logic [`LFSR_W-1:0] lfsr_t;

	// Step hits, bits 0..4 are steps, bit 5 is the lock-up state
	typedef logic [5:0] pla_t;

	// CPU write data
	typedef logic [7:0] apu_data_t;

	// Fields of a 4017 write
	typedef struct packed {
		logic mode;         // Bit 7, five-step mode
		logic irq_inhibit;  // Bit 6
	} frame_wr_t;

	// Frame pulses to the channels
	typedef struct packed {
		logic quarter;  // Envelopes and linear counter
		logic half;     // Length counters and sweeps
	} lfo_t;

	// Write-restart sequencer
	typedef enum logic [1:0] {
		idle,
		armed,  // Write seen, aclk low next cycle
		fire    // Clear on this aclk
	} restart_e;

endpackage

// File: aclk_gen.sv
`timescale 1ns/1ns

module aclk_gen (
	input  logic phi1,
	input  logic reset,
	output logic aclk
);

	logic aclk_q;

	// Toggle every phi1, low in the first cycle after reset
	always_ff @(posedge phi1) begin
		if (reset) begin
			aclk_q <= 1'b0;
		end else begin
			aclk_q <= ~aclk_q;
		end
	end

	assign aclk = aclk_q;

endmodule

// File: frame_ctl.sv
`timescale 1ns/1ns

module frame_ctl (
	input  logic               phi1,
	input  logic               reset,
	input  logic               aclk,
	input  logic               wr_4017,
	input  apu_pkg::frame_wr_t wr,
	input  logic               rd_4015,
	input  logic               dmc_int,
	input  apu_pkg::pla_t      pla,
	output logic               mode,
	output logic               status_irq,
	output logic               int_out
);

	logic mode_q;
	logic inhibit_q;
	logic irq_q;
	logic irq_set;
	logic irq_clr;
	logic status_q;
	logic int_q;

	// Mode and inhibit bits of register 4017
	always_ff @(posedge phi1) begin
		if (reset) begin
			mode_q    <= 1'b0;
			inhibit_q <= 1'b0;
		end else if (wr_4017) begin
			mode_q    <= wr.mode;
			inhibit_q <= wr.irq_inhibit;
		end
	end

	// Hit 3 only reaches here in four-step mode
	assign irq_set = aclk & pla[3] & ~mode_q & ~inhibit_q;

	// Status read, inhibit held, or inhibit being written
	assign irq_clr = rd_4015 | inhibit_q | (wr_4017 & wr.irq_inhibit);

	// Frame interrupt flag, clear wins over set
	always_ff @(posedge phi1) begin
		if (reset) begin
			irq_q <= 1'b0;
		end else if (irq_clr) begin
			irq_q <= 1'b0;
		end else if (irq_set) begin
			irq_q <= 1'b1;
		end
	end

	// Status bit seen by a 4015 read
	always_ff @(posedge phi1) begin
		if (reset) begin
			status_q <= 1'b0;
		end else if (aclk) begin
			status_q <= irq_q;
		end
	end

	// Interrupt line to the CPU
	always_ff @(posedge phi1) begin
		if (reset) begin
			int_q <= 1'b0;
		end else begin
			int_q <= irq_q | dmc_int;  // Shared with the DMC channel
		end
	end

	assign mode       = mode_q;
	assign status_irq = status_q;
	assign int_out    = int_q;

endmodule

// File: frame_lfsr.sv
`timescale 1ns/1ns
`include "apu_consts.svh"

module frame_lfsr (
	input  logic           phi1,
	input  logic           reset,
	input  logic           aclk,
	input  logic           wr_4017,
	input  logic           mode,
	input  apu_pkg::pla_t  pla,
	output apu_pkg::lfsr_t state,
	output logic           restart_hit
);

	apu_pkg::restart_e rs_q;
	apu_pkg::restart_e rs_d;
	apu_pkg::lfsr_t    state_q;
	apu_pkg::lfsr_t    state_d;
	logic              restart_pend;
	logic              frame_end;
	logic              lfsr_clear;
	logic              lfsr_step;
	logic              fb_a;
	logic              fb_b;
	logic              shift_in;

	// The fire state always lands on a cycle with aclk high
	always_comb begin
		rs_d = rs_q;
		case (rs_q)
			apu_pkg::idle: begin
				rs_d = apu_pkg::idle;
			end
			apu_pkg::armed: begin
				rs_d = apu_pkg::fire;  // Aclk is high next cycle
			end
			apu_pkg::fire: begin
				rs_d = apu_pkg::idle;
			end
			default: begin
				rs_d = apu_pkg::idle;
			end
		endcase
		if (wr_4017) begin
			// A new write restarts the wait
			if (aclk) begin
				rs_d = apu_pkg::armed;
			end else begin
				rs_d = apu_pkg::fire;
			end
		end
	end

	always_ff @(posedge phi1) begin
		if (reset) begin
			rs_q <= apu_pkg::idle;
		end else begin
			rs_q <= rs_d;
		end
	end

	assign restart_pend = aclk & (rs_q == apu_pkg::fire);

	// Extra pulse only when the write selected five-step mode
	assign restart_hit = restart_pend & mode;

	// Hit 3 arrives already masked in five-step mode
	assign frame_end = pla[3] | pla[4];

	assign lfsr_clear = aclk & (frame_end | restart_pend);
	assign lfsr_step  = aclk & ~lfsr_clear;

	// Feedback taps, with a forced one out of the lock-up state
	assign fb_a     = state_q[`LFSR_W-2];
	assign fb_b     = state_q[`LFSR_W-1];
	assign shift_in = (fb_a ^ fb_b) | pla[5];

	always_comb begin
		state_d = state_q;
		if (lfsr_clear) begin
			state_d = '1;
		end else if (lfsr_step) begin
			state_d = {state_q[`LFSR_W-2:0], shift_in};
		end
	end

	always_ff @(posedge phi1) begin
		if (reset) begin
			state_q <= '1;  // Start of a frame
		end else begin
			state_q <= state_d;
		end
	end

	assign state = state_q;

endmodule

// File: frame_pla.sv
`timescale 1ns/1ns
`include "apu_consts.svh"

module frame_pla (
	input  apu_pkg::lfsr_t state,
	input  logic           mode,
	output apu_pkg::pla_t  pla
);

	logic [4:0] step_match;
	logic       step3_hit;
	logic       lock_match;

	// One full compare per step
	always_comb begin
		step_match[0] = (state == `PLA_0);
		step_match[1] = (state == `PLA_1);
		step_match[2] = (state == `PLA_2);
		step_match[3] = (state == `PLA_3);
		step_match[4] = (state == `PLA_4);
	end

	// Step 3 ends the frame in four-step mode only
	assign step3_hit = step_match[3] & ~mode;

	assign lock_match = (state == `PLA_LOCK);

	assign pla = {
		lock_match,
		step_match[4],
		step3_hit,
		step_match[2:0]
	};

endmodule

// File: soft_timer.sv
`timescale 1ns/1ns

module soft_timer (
	input  logic               phi1,
	input  logic               reset,
	input  logic               wr_4017,
	input  apu_pkg::apu_data_t wr_data,
	input  logic               rd_4015,
	input  logic               dmc_int,
	output logic               aclk,
	output apu_pkg::lfo_t      lfo,
	output logic               status_irq,
	output logic               int_out
);

	apu_pkg::frame_wr_t wr;
	apu_pkg::pla_t      pla;
	apu_pkg::lfsr_t     state;
	apu_pkg::lfo_t      lfo_d;
	apu_pkg::lfo_t      lfo_q;
	logic               aclk_en;
	logic               mode;
	logic               restart_hit;
	logic               quarter_hit;
	logic               half_hit;

	assign wr.mode        = wr_data[7];
	assign wr.irq_inhibit = wr_data[6];

	aclk_gen aclk_gen_i (
		.phi1  (phi1),
		.reset (reset),
		.aclk  (aclk_en)
	);

	frame_ctl frame_ctl_i (
		.phi1       (phi1),
		.reset      (reset),
		.aclk       (aclk_en),
		.wr_4017    (wr_4017),
		.wr         (wr),
		.rd_4015    (rd_4015),
		.dmc_int    (dmc_int),
		.pla        (pla),
		.mode       (mode),
		.status_irq (status_irq),
		.int_out    (int_out)
	);

	frame_lfsr frame_lfsr_i (
		.phi1        (phi1),
		.reset       (reset),
		.aclk        (aclk_en),
		.wr_4017     (wr_4017),
		.mode        (mode),
		.pla         (pla),
		.state       (state),
		.restart_hit (restart_hit)
	);

	frame_pla frame_pla_i (
		.state (state),
		.mode  (mode),
		.pla   (pla)
	);

	// Every step clocks the quarter frame
	assign quarter_hit = (|pla[4:0]) | restart_hit;

	// Every second step clocks the half frame
	assign half_hit = pla[1] | pla[3] | pla[4] | restart_hit;

	// Hits last two phi1 cycles, aclk picks one
	assign lfo_d.quarter = aclk_en & quarter_hit;
	assign lfo_d.half    = aclk_en & half_hit;

	always_ff @(posedge phi1) begin
		if (reset) begin
			lfo_q <= '0;
		end else begin
			lfo_q <= lfo_d;
		end
	end

	assign lfo  = lfo_q;
	assign aclk = aclk_en;

endmodule

// File: tb_soft_timer_chk.sv
`timescale 1ns/1ns
`include "apu_consts.svh"

module tb_soft_timer_chk (
	input  logic               phi1,
	input  logic               reset,
	input  logic               wr_4017,
	input  apu_pkg::apu_data_t wr_data,
	input  logic               rd_4015,
	input  logic               dmc_int,
	input  logic               aclk,
	input  apu_pkg::lfo_t      lfo,
	input  logic               status_irq,
	input  logic               int_out,
	output int                 err_cnt
);

	int unsigned   cnt;  // Aclk steps since the last frame clear
	logic          aclk_ref;
	logic          pend;  // Write seen, clear on the next aclk
	logic          mode_ref;
	logic          inh_ref;
	logic          flag_ref;
	logic          status_ref;
	logic          int_ref;
	apu_pkg::lfo_t lfo_ref;
	logic          hit3;
	logic          frame_end;
	logic          restart;

	assign hit3      = (cnt == `STEP_3) & ~mode_ref;
	assign frame_end = hit3 | (cnt == `STEP_4);
	assign restart   = pend & mode_ref;  // Extra pulse in five-step mode only

	always_ff @(posedge phi1) begin
		if (reset) begin
			cnt        <= 0;
			aclk_ref   <= 1'b0;
			pend       <= 1'b0;
			mode_ref   <= 1'b0;
			inh_ref    <= 1'b0;
			flag_ref   <= 1'b0;
			status_ref <= 1'b0;
			int_ref    <= 1'b0;
			lfo_ref    <= '0;
		end else begin
			aclk_ref        <= ~aclk_ref;
			lfo_ref.quarter <= aclk_ref & (frame_end | restart | (cnt == `STEP_0)
				| (cnt == `STEP_1) | (cnt == `STEP_2));
			lfo_ref.half    <= aclk_ref & (frame_end | restart | (cnt == `STEP_1));
			if (aclk_ref) begin
				cnt        <= (pend | frame_end) ? 0 : cnt + 1;
				pend       <= 1'b0;
				status_ref <= flag_ref;
			end
			if (wr_4017) begin
				pend     <= 1'b1;
				mode_ref <= wr_data[7];
				inh_ref  <= wr_data[6];
			end
			if (rd_4015 | inh_ref | (wr_4017 & wr_data[6])) begin
				flag_ref <= 1'b0;
			end else if (aclk_ref & hit3) begin
				flag_ref <= 1'b1;
			end
			int_ref <= flag_ref | dmc_int;
		end
	end

	initial err_cnt = 0;

	task automatic report_mismatch(input string name, input logic [1:0] got,
		input logic [1:0] want);
		err_cnt = err_cnt + 1;
		$display("** Error at %0t ns: %s is %0b, expected %0b", $time, name, got, want);
	endtask

	assert property (@(posedge phi1) disable iff (reset) aclk == aclk_ref)
		else report_mismatch("aclk", $sampled(aclk), $sampled(aclk_ref));
	assert property (@(posedge phi1) disable iff (reset) lfo == lfo_ref)
		else report_mismatch("lfo", $sampled(lfo), $sampled(lfo_ref));
	assert property (@(posedge phi1) disable iff (reset) status_irq == status_ref)
		else report_mismatch("status_irq", $sampled(status_irq), $sampled(status_ref));
	assert property (@(posedge phi1) disable iff (reset) int_out == int_ref)
		else report_mismatch("int_out", $sampled(int_out), $sampled(int_ref));

endmodule

// File: tb_soft_timer.sv
`timescale 1ns/1ns
`include "apu_consts.svh"

module tb_soft_timer;

	localparam int step_gap = 2 * (`STEP_4 - `STEP_2) + 16;  // Step 2 to step 4 in phi1 cycles

	logic               phi1;
	logic               reset;
	logic               wr_4017;
	apu_pkg::apu_data_t wr_data;
	logic               rd_4015;
	logic               dmc_int;
	logic               aclk;
	apu_pkg::lfo_t      lfo;
	logic               status_irq;
	logic               int_out;
	int                 err_cnt;
	int                 timeout_cnt;
	int unsigned        seed_val;

	soft_timer soft_timer_i (.*);

	tb_soft_timer_chk chk_i (.*);

	initial begin
		phi1 = 1'b0;
		forever #2 phi1 = ~phi1;
	end

	// Codes 0 and 1 wait for quarter and half pulses
	// Codes 2 and 3 wait for status set and status clear
	// Codes 4 and 5 wait for aclk low and aclk high
	task automatic wait_for(input int sel, input int limit, input string what);
		int   n;
		logic hit;
		n   = 0;
		hit = 1'b0;
		while (hit !== 1'b1 && n < limit) begin
			@(posedge phi1);
			#1;
			n = n + 1;
			case (sel)
				0: hit = lfo.quarter;
				1: hit = lfo.half;
				2: hit = status_irq;
				3: hit = ~status_irq;
				4: hit = ~aclk;
				default: hit = aclk;
			endcase
		end
		if (hit !== 1'b1) begin
			timeout_cnt = timeout_cnt + 1;
			$display("Timeout at %0t ns: no %s within %0d cycles", $time, what, limit);
		end
	endtask

	// One-cycle write to 4017
	task automatic write_reg(input apu_pkg::apu_data_t data);
		wr_4017 = 1'b1;
		wr_data = data;
		@(posedge phi1);
		#1;
		wr_4017 = 1'b0;
		wr_data = '0;
	endtask

	initial begin
		seed_val    = $urandom(32'hbe73_6e75);
		timeout_cnt = 0;
		reset       = 1'b1;
		wr_4017     = 1'b0;
		wr_data     = '0;
		rd_4015     = 1'b0;
		dmc_int     = 1'b0;
		repeat (5) @(posedge phi1);
		#1;
		reset = 1'b0;

		// Four-step mode from reset
		wait_for(2, 2 * `STEP_3 + 16, "frame interrupt after reset");
		repeat (2 + $urandom % 40) @(posedge phi1);
		#1;
		rd_4015 = 1'b1;
		@(posedge phi1);
		#1;
		rd_4015 = 1'b0;
		wait_for(3, 8, "status clear after a 4015 read");
		repeat (200) begin  // DMC interrupt toggles while the frame flag is clear
			dmc_int = $urandom % 2;
			@(posedge phi1);
			#1;
		end
		dmc_int = 1'b0;
		wait_for(2, 2 * `STEP_3 + 16, "frame interrupt in the second frame");
		repeat (2 + $urandom % 40) @(posedge phi1);
		#1;
		write_reg(8'h40);
		wait_for(3, 8, "status clear after an inhibit write");
		repeat (5) wait_for(0, step_gap, "quarter frame pulse with inhibit set");

		// Five-step mode, written once in each aclk phase
		for (int p = 0; p < 2; p++) begin
			wait_for(4 + p, 4, "aclk phase before a five-step write");
			write_reg(8'h80);
			wait_for(1, 4, "immediate half frame pulse");
			repeat (6) wait_for(0, step_gap, "five-step quarter frame pulse");
		end

		$display("Errors: %0d assertion failures, %0d timeouts", err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+.
apu_pkg.sv
aclk_gen.sv
frame_ctl.sv
frame_lfsr.sv
frame_pla.sv
soft_timer.sv
tb_soft_timer_chk.sv
tb_soft_timer.sv
